/* dv/tbSingleCpu.sv */
`timescale 1ns/1ps

module tbSingleCpu import cpuPkg::*; ();

    localparam int progLen = 200;
    localparam int timeoutNs = (2 * progLen + 50) * 40;  // Load, run and margin
    localparam logic [31:0] haltAddr = 32'(4 * (progLen - 1));

    // Kinds 0-7 add sub and or xor slt sll srl, 8-12 addi andi ori xori slti
    localparam logic [4:0] kindLw  = 5'd13;
    localparam logic [4:0] kindSw  = 5'd14;
    localparam logic [4:0] kindBeq = 5'd15;
    localparam logic [4:0] kindBne = 5'd16;
    localparam logic [2:0] f3Of [16] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd1, 3'd5,
                                         3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd0, 3'd0, 3'd0};

    typedef struct packed {
        logic [4:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
    } genS;

    // Expected DUT outputs for one instruction cycle
    typedef struct packed {
        logic [31:0] pc;
        wbS          wb;
        logic        isLoad;
        logic        stEn;
        logic [31:0] stAddr;
        logic [31:0] stData;
    } stepS;

    logic        CLK;
    logic        arstN;
    logic        run;
    logic        loadEn;
    logic [31:0] loadAddr;
    logic [31:0] loadData;
    logic [31:0] pc;
    logic [31:0] instr;
    wbS          wb;
    logic        storeEn;
    logic [31:0] storeAddr;
    logic [31:0] storeData;

    integer      seed;
    genS         gen [progLen];
    logic [31:0] prog [progLen];
    stepS        steps [$];
    int          modelWbs;
    int          modelStores;
    int          dutWbs;
    int          dutStores;
    int          errs [5];
    int          checks [5];
    string       names [5];

    singleCpu #(.imemWords(256), .dmemWords(256)) dut (.*);

    always #20 CLK = ~CLK;

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] randImm12();
        logic [11:0] v;
        v = 12'(pick(4096));
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] encode(input genS g);
        logic [2:0] f3;
        f3 = f3Of[g.kind[3:0]];
        if (g.kind < 5'd8) begin
            return {(g.kind == 5'd1) ? 7'h20 : 7'h00, g.rs2, g.rs1, f3, g.rd, OP_RTYPE};
        end else if (g.kind < kindLw) begin
            return {g.imm[11:0], g.rs1, f3, g.rd, OP_ITYPE};
        end else if (g.kind == kindLw) begin
            return {g.imm[11:0], 5'd0, 3'b010, g.rd, OP_LOAD};
        end else if (g.kind == kindSw) begin
            return {g.imm[11:5], g.rs2, 5'd0, 3'b010, g.imm[4:0], OP_STORE};
        end
        // B format scatters imm[12|10:5] and imm[4:1|11]
        return {g.imm[12], g.imm[10:5], g.rs2, g.rs1, 2'b00, g.kind == kindBne,
                g.imm[4:1], g.imm[11], OP_BRANCH};
    endfunction

    task automatic genProgram();
        genS g;
        int  off;
        for (int p = 0; p < progLen; p++) begin
            g = '0;
            if (p < 7) begin                    // addi x1..x7 seeds the registers
                g.kind = 5'd8;
                g.rd   = 5'(p + 1);
                g.imm  = randImm12();
            end else if (p < 71) begin          // Pre-write all 64 reachable data words
                g.kind = kindSw;
                g.rs2  = 5'(1 + p % 7);
                g.imm  = 32'(4 * (p - 7));
            end else if (p < progLen - 1) begin
                g.kind = 5'(pick(17));
                if (g.kind >= kindBeq && p > progLen - 3) g.kind = 5'd8;  // No room to branch
                g.rd  = 5'(pick(8));
                g.rs1 = 5'(pick(8));
                g.rs2 = 5'(pick(8));
                if (g.kind >= kindBeq) begin
                    off = 8 + 4 * pick(7);
                    if (off > 4 * (progLen - 1 - p)) off = 4 * (progLen - 1 - p);
                    g.imm = 32'(off);
                end else if (g.kind >= kindLw) begin
                    g.rs1 = 5'd0;
                    g.imm = 32'(4 * pick(64));
                end else if (g.kind >= 5'd8) begin
                    g.imm = randImm12();
                end
            end else begin
                g.kind = kindBeq;               // beq x0,x0,0 halt
            end
            gen[p]  = g;
            prog[p] = encode(g);
        end
    endtask

    task automatic runModel();
        logic [31:0] mr [8];
        logic [31:0] md [64];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] mpc;
        genS         g;
        stepS        s;
        foreach (mr[r]) mr[r] = '0;
        mpc = '0;
        while (mpc != haltAddr) begin
            g = gen[int'(mpc >> 2)];
            a = mr[g.rs1[2:0]];
            b = (g.kind < 5'd8 || g.kind >= kindSw) ? mr[g.rs2[2:0]] : g.imm;
            s = '0;
            s.pc = mpc;
            mpc = mpc + 32'd4;
            case (g.kind)
                5'd0, 5'd8:  res = a + b;
                5'd1:        res = a - b;
                5'd2, 5'd9:  res = a & b;
                5'd3, 5'd10: res = a | b;
                5'd4, 5'd11: res = a ^ b;
                5'd5, 5'd12: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                5'd6:        res = a << b[4:0];
                5'd7:        res = a >> b[4:0];
                5'd13:       res = md[g.imm[7:2]];  // Base is always x0
                default:     res = '0;
            endcase
            if (g.kind == kindSw) begin
                md[g.imm[7:2]] = b;
                s.stEn   = 1'b1;
                s.stAddr = g.imm;
                s.stData = b;
                modelStores++;
            end else if (g.kind >= kindBeq) begin
                if ((a == b) != (g.kind == kindBne)) mpc = s.pc + g.imm;
            end else if (g.rd != 5'd0) begin
                mr[g.rd[2:0]] = res;
                s.wb     = '{1'b1, g.rd, res};
                s.isLoad = (g.kind == kindLw);
                modelWbs++;
            end
            steps.push_back(s);
        end
    endtask

    task automatic reportError(input int beh, input string msg);
        errs[beh]++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic checkStep(input stepS s);
        int beh;
        beh = s.isLoad ? 2 : 1;
        checks[3]++;
        checks[beh]++;
        checks[2]++;
        if (wb.valid === 1'b1) dutWbs++;
        if (storeEn === 1'b1) dutStores++;
        if (pc !== s.pc) begin
            reportError(3, $sformatf("pc is %h, model expects %h", pc, s.pc));
        end
        if (instr !== prog[int'(s.pc >> 2)]) begin
            reportError(3, $sformatf("instr is %h at pc %h, program holds %h",
                instr, pc, prog[int'(s.pc >> 2)]));
        end
        if (wb.valid === 1'b1 && wb.rd == 5'd0) begin
            reportError(1, $sformatf("write-back pulse for x0 at pc %h", pc));
        end
        if (wb.valid !== s.wb.valid ||
            (s.wb.valid && (wb.rd !== s.wb.rd || wb.data !== s.wb.data))) begin
            reportError(beh, $sformatf("wb %b x%0d=%h at pc %h, model expects %b x%0d=%h",
                wb.valid, wb.rd, wb.data, pc, s.wb.valid, s.wb.rd, s.wb.data));
        end
        if (storeEn !== s.stEn ||
            (s.stEn && (storeAddr !== s.stAddr || storeData !== s.stData))) begin
            reportError(2, $sformatf("store %b [%h]=%h, model expects %b [%h]=%h",
                storeEn, storeAddr, storeData, s.stEn, s.stAddr, s.stData));
        end
    endtask

    task automatic printResult(input int b);
        $display("%s: %0d checks, %0d errors, %s", names[b], checks[b], errs[b],
                 (errs[b] == 0) ? "passed" : "failed");
    endtask

    initial begin
        int   idx;
        int   failed;
        logic halted;
        seed     = 32'h7b294c26;
        CLK      = 1'b0;
        arstN    = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        names    = '{"Reset state", "ALU write-back", "Loads and stores", "Branches",
                     "Completion"};
        foreach (errs[b]) begin
            errs[b]   = 0;
            checks[b] = 0;
        end
        modelWbs    = 0;
        modelStores = 0;
        dutWbs      = 0;
        dutStores   = 0;
        genProgram();
        runModel();
        repeat (2) @(negedge CLK);
        arstN = 1'b1;
        for (int p = 0; p < progLen; p++) begin  // CPU stays stopped while loading
            @(negedge CLK);
            checks[0]++;
            if (pc !== 32'd0 || wb.valid !== 1'b0 || storeEn !== 1'b0) begin
                reportError(0, $sformatf("pc %h wb.valid %b storeEn %b while stopped",
                    pc, wb.valid, storeEn));
            end
            loadEn   = 1'b1;
            loadAddr = 32'(4 * p);
            loadData = prog[p];
        end
        @(negedge CLK);
        loadEn = 1'b0;
        run    = 1'b1;
        printResult(0);
        idx    = 0;
        halted = 1'b0;
        while (!halted && idx <= steps.size()) begin
            @(posedge CLK);                      // Outputs of the retiring instruction
            if (pc === haltAddr) begin
                halted = 1'b1;
            end else begin
                if (idx < steps.size()) checkStep(steps[idx]);
                idx++;
            end
        end
        @(negedge CLK);
        run = 1'b0;
        checks[4] += 3;
        if (!halted || idx != steps.size()) begin
            errs[4]++;
            $display("The CPU did not halt after the expected %0d instructions", steps.size());
        end
        if (dutWbs != modelWbs) begin
            reportError(4, $sformatf("%0d write-backs, model expects %0d", dutWbs, modelWbs));
        end
        if (dutStores != modelStores) begin
            reportError(4, $sformatf("%0d stores, model expects %0d", dutStores, modelStores));
        end
        for (int b = 1; b < 5; b++) printResult(b);
        failed = 0;
        foreach (errs[b]) begin
            if (errs[b] != 0) failed++;
        end
        $display("Behaviors passed: %0d, failed: %0d", 5 - failed, failed);
        if (failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("Timeout: the run did not finish within %0d ns", timeoutNs);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  aluOpE       op,
    output logic [31:0] result,
    output logic        zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};  // Signed compare
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;  // Logical
            default: result = '0;
        endcase
    end

    // Branch compare via ALU_SUB
    assign zero = (result == '0);

endmodule

/* logic/cpuPkg.sv */
package cpuPkg;

    // Base opcodes of the RV32I subset
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
    } aluOpE;

    typedef struct packed {
        logic  regWrite;
        logic  aluSrcImm;  // Operand b from immediate
        logic  memWrite;
        logic  memToReg;   // Write back the loaded word
        logic  branch;
        logic  branchNe;   // Invert zero test for bne
        aluOpE aluOp;
    } ctrlS;

    // Instruction formats
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmtS;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmtS;

    // S and B share one bit layout, only the immediate meaning differs
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } splitFmtS;

    typedef union packed {
        rFmtS     r;
        iFmtS     i;
        splitFmtS s;
        splitFmtS b;
    } instrU;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wbS;

endpackage

/* logic/dataMem.sv */
`timescale 1ns/1ps

module dataMem #(
    parameter int dmemWords = 256
) (
    input  logic        CLK,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int addrW = $clog2(dmemWords);

    logic [31:0] mem [dmemWords];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[addr[addrW+1:2]] <= wdata;
        end
    end

    assign rdata = mem[addr[addrW+1:2]];  // Wraps at depth

    // Word accesses only
    storeAligned: assert property (@(posedge CLK) we |-> (addr[1:0] == 2'b00));

endmodule

/* logic/immGen.sv */
`timescale 1ns/1ps

module immGen import cpuPkg::*; (
    input  instrU       instr,
    output logic [31:0] imm
);

    always_comb begin
        case (instr.r.opcode)
            OP_ITYPE, OP_LOAD: begin
                imm = {{20{instr.i.imm12[11]}}, instr.i.imm12};
            end
            OP_STORE: begin
                imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            end
            OP_BRANCH: begin
                // imm[12|10:5] high, imm[4:1|11] low
                imm = {{19{instr.b.immHi[6]}},
                       instr.b.immHi[6],
                       instr.b.immLo[0],
                       instr.b.immHi[5:0],
                       instr.b.immLo[4:1],
                       1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* logic/instMem.sv */
`timescale 1ns/1ps

module instMem import cpuPkg::*; #(
    parameter int imemWords = 256
) (
    input  logic        CLK,
    input  logic        loadEn,
    input  logic [31:0] loadAddr,  // Byte address
    input  logic [31:0] loadData,
    input  logic [31:0] pc,
    output instrU       instr
);

    localparam int addrW = $clog2(imemWords);

    instrU mem [imemWords];

    always_ff @(posedge CLK) begin
        if (loadEn) begin
            mem[loadAddr[addrW+1:2]] <= loadData;
        end
    end

    assign instr = mem[pc[addrW+1:2]];  // Combinational fetch

endmodule

/* logic/mainControl.sv */
`timescale 1ns/1ps

module mainControl import cpuPkg::*; (
    input  instrU instr,
    output ctrlS  ctrl
);

    // Shared funct3 decode where sub only picks add or sub
    function automatic aluOpE decodeFunct3(input logic [2:0] funct3, input logic sub);
        aluOpE op;
        case (funct3)
            3'b000:  op = sub ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b100:  op = ALU_XOR;
            3'b101:  op = ALU_SRL;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl = '0;             // Unknown opcode runs as a no-op
        ctrl.aluOp = ALU_ADD;
        case (instr.r.opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = decodeFunct3(instr.r.funct3, instr.r.funct7[5]);
            end
            OP_ITYPE: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = decodeFunct3(instr.i.funct3, 1'b0);
            end
            OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg  = 1'b1;
            end
            OP_STORE: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = instr.b.funct3[0];  // bne
                ctrl.aluOp    = ALU_SUB;
            end
            default: ;
        endcase
    end

endmodule

/* logic/progCounter.sv */
`timescale 1ns/1ps

module progCounter import cpuPkg::*; #(
    parameter int imemWords = 256
) (
    input  logic        CLK,
    input  logic        arstN,
    input  logic        run,
    input  ctrlS        ctrl,
    input  logic        zero,
    input  logic [31:0] imm,
    output logic [31:0] pc
);

    logic        taken;
    logic [31:0] nextPc;

    // beq takes on zero, bne on nonzero
    assign taken  = ctrl.branch && (zero != ctrl.branchNe);
    assign nextPc = taken ? pc + imm : pc + 32'd4;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (run) begin
            pc <= nextPc;   // Hold while stopped
        end
    end

    // Fetch stays aligned and inside the instruction RAM
    pcInRange: assert property (@(posedge CLK) disable iff (!arstN)
        (pc[1:0] == 2'b00) && ((pc >> 2) < imemWords));

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic        CLK,
    input  logic        arstN,
    input  logic        we,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero regardless of storage
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* logic/singleCpu.sv */
`timescale 1ns/1ps

module singleCpu import cpuPkg::*; #(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  logic        CLK,
    input  logic        arstN,
    input  logic        run,
    input  logic        loadEn,
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData,
    output logic [31:0] pc,
    output logic [31:0] instr,
    output wbS          wb,
    output logic        storeEn,
    output logic [31:0] storeAddr,
    output logic [31:0] storeData
);

    instrU       instrWord;
    ctrlS        ctrl;
    logic [31:0] imm;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic        zero;
    logic [31:0] memRdata;
    logic [31:0] wbData;
    logic        regWe;

    progCounter #(.imemWords(imemWords)) uPc (
        .CLK(CLK), .arstN(arstN), .run(run), .ctrl(ctrl),
        .zero(zero), .imm(imm), .pc(pc)
    );

    instMem #(.imemWords(imemWords)) uImem (
        .CLK(CLK), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .pc(pc), .instr(instrWord)
    );

    mainControl uCtrl (.instr(instrWord), .ctrl(ctrl));

    regFile uRegs (
        .CLK(CLK), .arstN(arstN), .we(regWe),
        .rs1(instrWord.r.rs1), .rs2(instrWord.r.rs2), .rd(instrWord.r.rd),
        .wdata(wbData), .rdata1(rdata1), .rdata2(rdata2)
    );

    immGen uImm (.instr(instrWord), .imm(imm));

    assign aluB = ctrl.aluSrcImm ? imm : rdata2;  // Operand select

    alu uAlu (.a(rdata1), .b(aluB), .op(ctrl.aluOp), .result(aluResult), .zero(zero));

    dataMem #(.dmemWords(dmemWords)) uDmem (
        .CLK(CLK), .we(storeEn), .addr(aluResult), .wdata(rdata2), .rdata(memRdata)
    );

    assign wbData = ctrl.memToReg ? memRdata : aluResult;
    assign regWe  = run && ctrl.regWrite;

    // Observation port, valid during the instruction's own cycle
    assign instr     = instrWord;
    assign wb.valid  = regWe && (instrWord.r.rd != 5'd0);
    assign wb.rd     = instrWord.r.rd;
    assign wb.data   = wbData;
    assign storeEn   = run && ctrl.memWrite;
    assign storeAddr = aluResult;
    assign storeData = rdata2;

endmodule

/* run.sh */
#!/bin/sh
# Build the single-cycle CPU testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -j 0 -f singleCpu.f --top-module tbSingleCpu -o simSingleCpu \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/simSingleCpu > sim.log 2>&1 || echo "Simulation exited with an error" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

/* singleCpu.f */
logic/cpuPkg.sv
logic/mainControl.sv
logic/progCounter.sv
logic/instMem.sv
logic/regFile.sv
logic/immGen.sv
logic/alu.sv
logic/dataMem.sv
logic/singleCpu.sv
dv/tbSingleCpu.sv
